// ==== Makefile ====
# Verilator build and run of the mesh testbench

obj_dir/Vtb_core_complex: filelist.f common/mesh_defs.svh $(shell grep -v '^+' filelist.f)
	verilator --binary --timing --assert -f filelist.f --top-module tb_core_complex

.PHONY: run clean

run: obj_dir/Vtb_core_complex
	./obj_dir/Vtb_core_complex | tee sim.log
	@grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== common/mesh_defs.svh ====
`ifndef MESH_DEFS_SVH
`define MESH_DEFS_SVH

//////////////////////////////////////////////////////////////
// mesh geometry
//////////////////////////////////////////////////////////////
`define MESH_X_DIM 2
`define MESH_Y_DIM 2

// x coordinate also covers the host column at x = 0
`define MESH_XC_W 2
`define MESH_YC_W 1

//////////////////////////////////////////////////////////////
// payload and flow control
//////////////////////////////////////////////////////////////
`define MESH_ADDR_W 4
`define MESH_DATA_W 16
`define MESH_CREDITS 2

// local, west, east, north, south
`define MESH_PORTS 5

`endif

// ==== common/mesh_pkg.sv ====
`include "mesh_defs.svh"

package mesh_pkg;

  typedef enum logic [1:0]
  {
    e_op_rd = 2'd0
    , e_op_wr = 2'd1
    , e_op_rdata = 2'd2
    , e_op_wack = 2'd3
  } op_e;

  // router port numbering, also used to index link arrays
  typedef enum logic [2:0]
  {
    e_dir_p = 3'd0
    , e_dir_w = 3'd1
    , e_dir_e = 3'd2
    , e_dir_n = 3'd3
    , e_dir_s = 3'd4
  } dir_e;

  typedef struct packed
  {
    op_e                     op;
    logic [`MESH_XC_W-1:0]   dst_x;
    logic [`MESH_YC_W-1:0]   dst_y;
    logic [`MESH_XC_W-1:0]   src_x;
    logic [`MESH_YC_W-1:0]   src_y;
    logic [`MESH_ADDR_W-1:0] addr;
    logic [`MESH_DATA_W-1:0] data;
  } flit_s;

endpackage

// ==== filelist.f ====
+incdir+common
common/mesh_pkg.sv
router/credit_fifo.sv
router/mesh_router.sv
tile/tile_scratchpad.sv
tile/tile_node.sv
logic/core_complex.sv
tb/tb_clock.sv
tb/tb_core_complex.sv

// ==== logic/core_complex.sv ====
`timescale 1ns/1ps
`include "mesh_defs.svh"

module core_complex
  (input                                          core_clk_i
   , input                                        rst_n_i

   , input [`MESH_Y_DIM-1:0]                      host_req_v_i
   , input mesh_pkg::flit_s [`MESH_Y_DIM-1:0]     host_req_flit_i
   , output [`MESH_Y_DIM-1:0]                     host_req_credit_o

   , output [`MESH_Y_DIM-1:0]                     host_resp_v_o
   , output mesh_pkg::flit_s [`MESH_Y_DIM-1:0]    host_resp_flit_o
   , input [`MESH_Y_DIM-1:0]                      host_resp_credit_i
   );

  localparam int xd_lp = `MESH_X_DIM;
  localparam int yd_lp = `MESH_Y_DIM;

  // [network][row][column][compass port], network 0 is request, 1 is response
  logic [1:0][yd_lp-1:0][xd_lp-1:0][`MESH_PORTS-1:1]            in_v, in_credit;
  logic [1:0][yd_lp-1:0][xd_lp-1:0][`MESH_PORTS-1:1]            out_v, out_credit;
  mesh_pkg::flit_s [1:0][yd_lp-1:0][xd_lp-1:0][`MESH_PORTS-1:1] in_flit, out_flit;

  for (genvar j = 0; j < yd_lp; j++)
  begin : y
    for (genvar i = 0; i < xd_lp; i++)
    begin : x
      // host column is x = 0, so tiles start at 1
      tile_node
        #(.tile_x_p(i + 1)
          ,.tile_y_p(j)
          )
        tile
          (.core_clk_i(core_clk_i)
           ,.rst_n_i(rst_n_i)
           ,.req_in_v_i(in_v[0][j][i])
           ,.req_in_flit_i(in_flit[0][j][i])
           ,.req_in_credit_o(in_credit[0][j][i])
           ,.req_out_v_o(out_v[0][j][i])
           ,.req_out_flit_o(out_flit[0][j][i])
           ,.req_out_credit_i(out_credit[0][j][i])
           ,.resp_in_v_i(in_v[1][j][i])
           ,.resp_in_flit_i(in_flit[1][j][i])
           ,.resp_in_credit_o(in_credit[1][j][i])
           ,.resp_out_v_o(out_v[1][j][i])
           ,.resp_out_flit_o(out_flit[1][j][i])
           ,.resp_out_credit_i(out_credit[1][j][i])
           );
    end

    // west edge of column 1 is the host port of the row
    assign in_v[0][j][0][mesh_pkg::e_dir_w]       = host_req_v_i[j];
    assign in_flit[0][j][0][mesh_pkg::e_dir_w]    = host_req_flit_i[j];
    assign host_req_credit_o[j]                   = in_credit[0][j][0][mesh_pkg::e_dir_w];
    assign out_credit[0][j][0][mesh_pkg::e_dir_w] = 1'b0;

    assign in_v[1][j][0][mesh_pkg::e_dir_w]       = 1'b0;
    assign in_flit[1][j][0][mesh_pkg::e_dir_w]    = '0;
    assign host_resp_v_o[j]                       = out_v[1][j][0][mesh_pkg::e_dir_w];
    assign host_resp_flit_o[j]                    = out_flit[1][j][0][mesh_pkg::e_dir_w];
    assign out_credit[1][j][0][mesh_pkg::e_dir_w] = host_resp_credit_i[j];
  end

  //////////////////////////////////////////////////////////////
  // stitch, same for both networks
  //////////////////////////////////////////////////////////////
  for (genvar n = 0; n < 2; n++)
  begin : net
    for (genvar j = 0; j < yd_lp; j++)
    begin : y
      for (genvar i = 0; i < xd_lp; i++)
      begin : x
        if (i > 0)
        begin : hor
          assign in_v[n][j][i][mesh_pkg::e_dir_w]         = out_v[n][j][i-1][mesh_pkg::e_dir_e];
          assign in_flit[n][j][i][mesh_pkg::e_dir_w]      = out_flit[n][j][i-1][mesh_pkg::e_dir_e];
          assign out_credit[n][j][i-1][mesh_pkg::e_dir_e] = in_credit[n][j][i][mesh_pkg::e_dir_w];
          assign in_v[n][j][i-1][mesh_pkg::e_dir_e]       = out_v[n][j][i][mesh_pkg::e_dir_w];
          assign in_flit[n][j][i-1][mesh_pkg::e_dir_e]    = out_flit[n][j][i][mesh_pkg::e_dir_w];
          assign out_credit[n][j][i][mesh_pkg::e_dir_w]   = in_credit[n][j][i-1][mesh_pkg::e_dir_e];
        end

        if (i == xd_lp - 1)
        begin : e_edge
          assign in_v[n][j][i][mesh_pkg::e_dir_e]       = 1'b0;
          assign in_flit[n][j][i][mesh_pkg::e_dir_e]    = '0;
          assign out_credit[n][j][i][mesh_pkg::e_dir_e] = 1'b0;
        end

        // north is toward row 0
        if (j > 0)
        begin : ver
          assign in_v[n][j][i][mesh_pkg::e_dir_n]         = out_v[n][j-1][i][mesh_pkg::e_dir_s];
          assign in_flit[n][j][i][mesh_pkg::e_dir_n]      = out_flit[n][j-1][i][mesh_pkg::e_dir_s];
          assign out_credit[n][j-1][i][mesh_pkg::e_dir_s] = in_credit[n][j][i][mesh_pkg::e_dir_n];
          assign in_v[n][j-1][i][mesh_pkg::e_dir_s]       = out_v[n][j][i][mesh_pkg::e_dir_n];
          assign in_flit[n][j-1][i][mesh_pkg::e_dir_s]    = out_flit[n][j][i][mesh_pkg::e_dir_n];
          assign out_credit[n][j][i][mesh_pkg::e_dir_n]   = in_credit[n][j-1][i][mesh_pkg::e_dir_s];
        end
        else
        begin : n_edge
          assign in_v[n][j][i][mesh_pkg::e_dir_n]       = 1'b0;
          assign in_flit[n][j][i][mesh_pkg::e_dir_n]    = '0;
          assign out_credit[n][j][i][mesh_pkg::e_dir_n] = 1'b0;
        end

        if (j == yd_lp - 1)
        begin : s_edge
          assign in_v[n][j][i][mesh_pkg::e_dir_s]       = 1'b0;
          assign in_flit[n][j][i][mesh_pkg::e_dir_s]    = '0;
          assign out_credit[n][j][i][mesh_pkg::e_dir_s] = 1'b0;
        end
      end
    end
  end

endmodule

// ==== router/credit_fifo.sv ====
`timescale 1ns/1ps
`include "mesh_defs.svh"

module credit_fifo
  (input                      core_clk_i
   , input                    rst_n_i
   , input                    push_i
   , input mesh_pkg::flit_s   flit_i
   , input                    pop_i
   , output logic             empty_o
   , output mesh_pkg::flit_s  flit_o
   , output logic             credit_o
   );

  localparam int depth_lp = `MESH_CREDITS;
  localparam int ptr_w_lp = (depth_lp > 1) ? $clog2(depth_lp) : 1;
  localparam int cnt_w_lp = $clog2(depth_lp + 1);

  mesh_pkg::flit_s     mem [depth_lp];
  logic [ptr_w_lp-1:0] wr_ptr;
  logic [ptr_w_lp-1:0] rd_ptr;
  logic [cnt_w_lp-1:0] count;
  logic                do_pop;

  function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] ptr);
    if (ptr == ptr_w_lp'(depth_lp - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign empty_o  = (count == '0);
  assign do_pop   = pop_i & ~empty_o;
  assign flit_o   = mem[rd_ptr];
  // one credit per flit leaving the buffer
  assign credit_o = do_pop;

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)
        rd_ptr <= next_ptr(rd_ptr);
      count <= count + cnt_w_lp'(push_i) - cnt_w_lp'(do_pop);
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (push_i)
      mem[wr_ptr] <= flit_i;
  end

endmodule

// ==== router/mesh_router.sv ====
`timescale 1ns/1ps
`include "mesh_defs.svh"

module mesh_router
  #(parameter int tile_x_p = 1
    , parameter int tile_y_p = 0
    )
  (input                                        core_clk_i
   , input                                      rst_n_i
   , input [`MESH_PORTS-1:0]                    in_v_i
   , input mesh_pkg::flit_s [`MESH_PORTS-1:0]   in_flit_i
   , output [`MESH_PORTS-1:0]                   in_credit_o
   , output logic [`MESH_PORTS-1:0]             out_v_o
   , output mesh_pkg::flit_s [`MESH_PORTS-1:0]  out_flit_o
   , input [`MESH_PORTS-1:0]                    out_credit_i
   );

  localparam int ports_lp = `MESH_PORTS;
  localparam int idx_w_lp = $clog2(ports_lp);
  localparam int cnt_w_lp = $clog2(`MESH_CREDITS + 1);
  localparam logic [`MESH_XC_W-1:0] my_x_lp = `MESH_XC_W'(tile_x_p);
  localparam logic [`MESH_YC_W-1:0] my_y_lp = `MESH_YC_W'(tile_y_p);

  logic [ports_lp-1:0]                empty;
  logic [ports_lp-1:0]                pop;
  mesh_pkg::flit_s [ports_lp-1:0]     head;
  mesh_pkg::dir_e                     route [ports_lp];
  // grant[out][in]
  logic [ports_lp-1:0][ports_lp-1:0]  grant;
  logic [ports_lp-1:0][idx_w_lp-1:0]  grant_idx;
  logic [ports_lp-1:0][idx_w_lp-1:0]  rr_ptr;
  logic [ports_lp-1:0][cnt_w_lp-1:0]  credit_cnt;

  for (genvar i = 0; i < ports_lp; i++)
  begin : in_buf
    credit_fifo fifo
      (.core_clk_i(core_clk_i)
       ,.rst_n_i(rst_n_i)
       ,.push_i(in_v_i[i])
       ,.flit_i(in_flit_i[i])
       ,.pop_i(pop[i])
       ,.empty_o(empty[i])
       ,.flit_o(head[i])
       ,.credit_o(in_credit_o[i])
       );
  end

  //////////////////////////////////////////////////////////////
  // XY routing of each buffer head
  //////////////////////////////////////////////////////////////
  always_comb
  begin
    for (int i = 0; i < ports_lp; i++)
    begin
      // flits for the host column settle their row first since that column has no vertical links
      if (head[i].dst_x == '0 && head[i].dst_y > my_y_lp)
        route[i] = mesh_pkg::e_dir_s;
      else if (head[i].dst_x == '0 && head[i].dst_y < my_y_lp)
        route[i] = mesh_pkg::e_dir_n;
      else if (head[i].dst_x > my_x_lp)
        route[i] = mesh_pkg::e_dir_e;
      else if (head[i].dst_x < my_x_lp)
        route[i] = mesh_pkg::e_dir_w;
      else if (head[i].dst_y > my_y_lp)
        route[i] = mesh_pkg::e_dir_s;
      else if (head[i].dst_y < my_y_lp)
        route[i] = mesh_pkg::e_dir_n;
      else
        route[i] = mesh_pkg::e_dir_p;
    end
  end

  //////////////////////////////////////////////////////////////
  // round-robin arbitration per output
  //////////////////////////////////////////////////////////////
  always_comb
  begin
    int idx;
    grant     = '0;
    grant_idx = '0;
    for (int o = 0; o < ports_lp; o++)
    begin
      // search starts just after the last winner
      for (int k = 1; k <= ports_lp; k++)
      begin
        idx = (int'(rr_ptr[o]) + k) % ports_lp;
        if (credit_cnt[o] != '0 && grant[o] == '0
            && !empty[idx] && int'(route[idx]) == o)
        begin
          grant[o][idx] = 1'b1;
          grant_idx[o]  = idx_w_lp'(idx);
        end
      end
    end
  end

  always_comb
  begin
    pop = '0;
    for (int o = 0; o < ports_lp; o++)
      pop |= grant[o];
  end

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      out_v_o <= '0;
      for (int o = 0; o < ports_lp; o++)
      begin
        rr_ptr[o]     <= '0;
        credit_cnt[o] <= cnt_w_lp'(`MESH_CREDITS);
      end
    end
    else
    begin
      for (int o = 0; o < ports_lp; o++)
      begin
        out_v_o[o]    <= |grant[o];
        credit_cnt[o] <= credit_cnt[o] + cnt_w_lp'(out_credit_i[o]) - cnt_w_lp'(|grant[o]);
        if (|grant[o])
          rr_ptr[o] <= grant_idx[o];
      end
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    for (int o = 0; o < ports_lp; o++)
    begin
      if (|grant[o])
        out_flit_o[o] <= head[grant_idx[o]];
    end
  end

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock
  (output logic clk_o
   , output logic rst_n_o
   );

  int rst_cnt = 0;

  initial
  begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // reset low for the first 3 rising edges
  always @(posedge clk_o)
  begin
    if (rst_cnt < 3)
      rst_cnt <= rst_cnt + 1;
  end

  assign rst_n_o = (rst_cnt == 3);

endmodule

// ==== tb/tb_core_complex.sv ====
`timescale 1ns/1ps
`include "mesh_defs.svh"

module tb_core_complex;

  localparam int tiles_lp = `MESH_X_DIM * `MESH_Y_DIM;
  localparam int words_lp = 1 << `MESH_ADDR_W;
  localparam int buf_lp   = 128;
  // write/read pairs, row 1 reads, held reads, random writes and their reads
  localparam int trans_lp   = 2 * tiles_lp + tiles_lp + 6 + 2 * 40;
  localparam int timeout_lp = trans_lp * 40 + 200;

  logic clk;
  logic rst_n;

  logic [`MESH_Y_DIM-1:0]            host_req_v = '0;
  mesh_pkg::flit_s [`MESH_Y_DIM-1:0] host_req_flit = '0;
  logic [`MESH_Y_DIM-1:0]            host_req_credit;
  logic [`MESH_Y_DIM-1:0]            host_resp_v;
  mesh_pkg::flit_s [`MESH_Y_DIM-1:0] host_resp_flit;
  logic [`MESH_Y_DIM-1:0]            host_resp_credit = '0;

  // host side request buffers, filled by the test sequence
  mesh_pkg::flit_s req_buf [`MESH_Y_DIM][buf_lp];
  int              req_wr [`MESH_Y_DIM];
  int              req_rd [`MESH_Y_DIM];
  int              req_cnt [`MESH_Y_DIM];

  // expected responses per host row and tile, in issue order
  mesh_pkg::op_e         exp_op [`MESH_Y_DIM][tiles_lp][buf_lp];
  bit [`MESH_DATA_W-1:0] exp_data [`MESH_Y_DIM][tiles_lp][buf_lp];
  int                    exp_wr [`MESH_Y_DIM][tiles_lp];
  int                    exp_rd [`MESH_Y_DIM][tiles_lp];
  bit [`MESH_DATA_W-1:0] model_mem [tiles_lp][words_lp];

  bit                    chk_v [`MESH_Y_DIM];
  bit                    unexp [`MESH_Y_DIM];
  mesh_pkg::flit_s       got [`MESH_Y_DIM];
  mesh_pkg::op_e         exp_op_r [`MESH_Y_DIM];
  bit [`MESH_DATA_W-1:0] exp_data_r [`MESH_Y_DIM];
  int                    resp_owed [`MESH_Y_DIM];
  int                    resp_outst [`MESH_Y_DIM];
  bit                    hold_credit [`MESH_Y_DIM];

  int issued;
  int received;
  int cyc;
  int fail_cnt;
  int fail_mark;
  int tests_run;
  int tests_bad;
  int seed;
  bit touched [tiles_lp][words_lp];
  int owner [tiles_lp][words_lp];

  tb_clock clk_gen
    (.clk_o(clk)
     ,.rst_n_o(rst_n)
     );

  core_complex dut0
    (.core_clk_i(clk)
     ,.rst_n_i(rst_n)
     ,.host_req_v_i(host_req_v)
     ,.host_req_flit_i(host_req_flit)
     ,.host_req_credit_o(host_req_credit)
     ,.host_resp_v_o(host_resp_v)
     ,.host_resp_flit_o(host_resp_flit)
     ,.host_resp_credit_i(host_resp_credit)
     );

  function automatic int pick(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic int tile_of(input mesh_pkg::flit_s f);
    if (f.src_x == '0 || int'(f.src_x) > `MESH_X_DIM)
      return -1;
    return int'(f.src_y) * `MESH_X_DIM + int'(f.src_x) - 1;
  endfunction

  task automatic send_req(input int row, input mesh_pkg::op_e op, input int t, input int addr,
                          input bit [`MESH_DATA_W-1:0] data);
    mesh_pkg::flit_s f;
    int              w;
    f.op    = op;
    f.dst_x = `MESH_XC_W'(t % `MESH_X_DIM + 1);
    f.dst_y = `MESH_YC_W'(t / `MESH_X_DIM);
    f.src_x = '0;
    f.src_y = `MESH_YC_W'(row);
    f.addr  = `MESH_ADDR_W'(addr);
    f.data  = (op == mesh_pkg::e_op_wr) ? data : '0;
    w = exp_wr[row][t] % buf_lp;
    if (op == mesh_pkg::e_op_wr)
    begin
      exp_op[row][t][w]   = mesh_pkg::e_op_wack;
      exp_data[row][t][w] = data;
      model_mem[t][addr]  = data;
    end
    else
    begin
      exp_op[row][t][w]   = mesh_pkg::e_op_rdata;
      exp_data[row][t][w] = model_mem[t][addr];
    end
    exp_wr[row][t] = exp_wr[row][t] + 1;
    req_buf[row][req_wr[row] % buf_lp] = f;
    req_wr[row] = req_wr[row] + 1;
    issued = issued + 1;
  endtask

  task automatic drain();
    while (received != issued)
      @(negedge clk);
    // let the last response pass its checks
    repeat (2) @(negedge clk);
  endtask

  task automatic report_test(input string name);
    if (fail_cnt == fail_mark)
      $display("test %s ok", name);
    else
    begin
      $display("test %s had %0d errors", name, fail_cnt - fail_mark);
      tests_bad = tests_bad + 1;
    end
    tests_run = tests_run + 1;
    fail_mark = fail_cnt;
  endtask

  ////////////////////////////////////////////////////////////
  // host side sender and response sink
  ////////////////////////////////////////////////////////////
  always @(posedge clk)
  begin : sender
    int avail;
    if (!rst_n)
    begin
      host_req_v <= '0;
      for (int r = 0; r < `MESH_Y_DIM; r++)
        req_cnt[r] <= `MESH_CREDITS;
    end
    else
    begin
      for (int r = 0; r < `MESH_Y_DIM; r++)
      begin
        avail = req_cnt[r] + int'(host_req_credit[r]);
        if (req_rd[r] != req_wr[r] && avail > 0)
        begin
          host_req_v[r]    <= 1'b1;
          host_req_flit[r] <= req_buf[r][req_rd[r] % buf_lp];
          req_rd[r]        <= req_rd[r] + 1;
          avail = avail - 1;
        end
        else
          host_req_v[r] <= 1'b0;
        req_cnt[r] <= avail;
      end
    end
  end

  always @(posedge clk)
  begin : sink
    int t;
    int got_n;
    int owed_n;
    if (!rst_n)
    begin
      host_resp_credit <= '0;
      for (int r = 0; r < `MESH_Y_DIM; r++)
      begin
        chk_v[r]      <= 1'b0;
        resp_owed[r]  <= 0;
        resp_outst[r] <= 0;
      end
    end
    else
    begin
      got_n = 0;
      for (int r = 0; r < `MESH_Y_DIM; r++)
      begin
        chk_v[r] <= host_resp_v[r];
        got[r]   <= host_resp_flit[r];
        unexp[r] <= 1'b0;
        if (host_resp_v[r])
        begin
          got_n = got_n + 1;
          t = tile_of(host_resp_flit[r]);
          if (t < 0)
            unexp[r] <= 1'b1;
          else if (exp_rd[r][t] == exp_wr[r][t])
            unexp[r] <= 1'b1;
          else
          begin
            exp_op_r[r]   <= exp_op[r][t][exp_rd[r][t] % buf_lp];
            exp_data_r[r] <= exp_data[r][t][exp_rd[r][t] % buf_lp];
            exp_rd[r][t]  <= exp_rd[r][t] + 1;
          end
        end
        // one credit per received flit unless the test holds them back
        owed_n = resp_owed[r] + int'(host_resp_v[r]);
        if (!hold_credit[r] && owed_n > 0)
        begin
          host_resp_credit[r] <= 1'b1;
          owed_n = owed_n - 1;
        end
        else
          host_resp_credit[r] <= 1'b0;
        resp_owed[r]  <= owed_n;
        resp_outst[r] <= resp_outst[r] + int'(host_resp_v[r]) - int'(host_resp_credit[r]);
      end
      received <= received + got_n;
    end
  end

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc >= timeout_lp)
    begin
      $display("timeout after %0d cycles, %0d requests still without a response",
               cyc, issued - received);
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////
  rst_resp_quiet: assert property (@(posedge clk)
                                   (cyc >= 1 && cyc <= 4) |-> host_resp_v == '0)
  else
  begin
    $display("Mismatch host_resp_v_o in reset: got %h expected 0", $sampled(host_resp_v));
    fail_cnt = fail_cnt + 1;
  end

  rst_credit_quiet: assert property (@(posedge clk)
                                     (cyc >= 1 && cyc <= 4) |-> host_req_credit == '0)
  else
  begin
    $display("Mismatch host_req_credit_o in reset: got %h expected 0", $sampled(host_req_credit));
    fail_cnt = fail_cnt + 1;
  end

  for (genvar r = 0; r < `MESH_Y_DIM; r++)
  begin : row_chk
    op_ok: assert property (@(posedge clk) disable iff (!rst_n)
                            chk_v[r] && !unexp[r] |-> got[r].op == exp_op_r[r])
    else
    begin
      $display("Mismatch host_resp_flit_o[%0d].op: got %h expected %h",
               r, $sampled(got[r].op), $sampled(exp_op_r[r]));
      fail_cnt = fail_cnt + 1;
    end

    data_ok: assert property (@(posedge clk) disable iff (!rst_n)
                              chk_v[r] && !unexp[r] |-> got[r].data == exp_data_r[r])
    else
    begin
      $display("Mismatch host_resp_flit_o[%0d].data: got %h expected %h",
               r, $sampled(got[r].data), $sampled(exp_data_r[r]));
      fail_cnt = fail_cnt + 1;
    end

    // responses leave the mesh at the host column of their own row
    dst_ok: assert property (@(posedge clk) disable iff (!rst_n)
                             chk_v[r] |-> got[r].dst_x == '0 && got[r].dst_y == `MESH_YC_W'(r))
    else
    begin
      $display("Mismatch host_resp_flit_o[%0d].dst: got %h,%h expected 0,%h",
               r, $sampled(got[r].dst_x), $sampled(got[r].dst_y), r);
      fail_cnt = fail_cnt + 1;
    end

    known_ok: assert property (@(posedge clk) disable iff (!rst_n) chk_v[r] |-> !unexp[r])
    else
    begin
      $display("host row %0d received a response from tile (%0d,%0d) that no request there expects",
               r, $sampled(got[r].src_x), $sampled(got[r].src_y));
      fail_cnt = fail_cnt + 1;
    end

    hold_ok: assert property (@(posedge clk) disable iff (!rst_n)
                              resp_outst[r] <= `MESH_CREDITS)
    else
    begin
      $display("host row %0d holds %0d responses without a returned credit",
               r, $sampled(resp_outst[r]));
      fail_cnt = fail_cnt + 1;
    end

    cnt_ok: assert property (@(posedge clk) disable iff (!rst_n)
                             req_cnt[r] >= 0 && req_cnt[r] <= `MESH_CREDITS)
    else
    begin
      $display("request credit count of host row %0d left its range at %0d",
               r, $sampled(req_cnt[r]));
      fail_cnt = fail_cnt + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial
  begin : tests
    int                    t;
    int                    a;
    int                    row;
    bit [`MESH_DATA_W-1:0] d;
    seed = 37;
    while (cyc < 6)
      @(negedge clk);
    report_test("reset");

    for (int i = 0; i < tiles_lp; i++)
    begin
      a = pick(words_lp);
      d = `MESH_DATA_W'(pick(1 << `MESH_DATA_W));
      send_req(0, mesh_pkg::e_op_wr, i, a, d);
      drain();
      send_req(0, mesh_pkg::e_op_rd, i, a, '0);
      drain();
    end
    report_test("write_read");

    for (int i = 0; i < tiles_lp; i++)
    begin
      send_req(1, mesh_pkg::e_op_rd, i, pick(words_lp), '0);
      drain();
    end
    report_test("return_route");

    hold_credit[0] = 1'b1;
    for (int i = 0; i < 6; i++)
      send_req(0, mesh_pkg::e_op_rd, i % tiles_lp, pick(words_lp), '0);
    repeat (50) @(negedge clk);
    hold_credit[0] = 1'b0;
    drain();
    report_test("back_pressure");

    for (int i = 0; i < 40; i++)
    begin
      t = pick(tiles_lp);
      a = pick(words_lp);
      d = `MESH_DATA_W'(pick(1 << `MESH_DATA_W));
      // a word keeps one source row so its writes stay in order
      row = touched[t][a] ? owner[t][a] : pick(`MESH_Y_DIM);
      touched[t][a] = 1'b1;
      owner[t][a] = row;
      send_req(row, mesh_pkg::e_op_wr, t, a, d);
    end
    drain();
    for (int i = 0; i < tiles_lp; i++)
    begin
      for (int w = 0; w < words_lp; w++)
      begin
        if (touched[i][w])
          send_req(owner[i][w], mesh_pkg::e_op_rd, i, w, '0);
      end
    end
    drain();
    report_test("random_traffic");

    $display("tests run %0d, tests with errors %0d, errors %0d", tests_run, tests_bad, fail_cnt);
    if (fail_cnt == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// ==== tile/tile_node.sv ====
`timescale 1ns/1ps
`include "mesh_defs.svh"

module tile_node
  #(parameter int tile_x_p = 1
    , parameter int tile_y_p = 0
    )
  (input                                          core_clk_i
   , input                                        rst_n_i

   , input [`MESH_PORTS-1:1]                      req_in_v_i
   , input mesh_pkg::flit_s [`MESH_PORTS-1:1]     req_in_flit_i
   , output [`MESH_PORTS-1:1]                     req_in_credit_o
   , output [`MESH_PORTS-1:1]                     req_out_v_o
   , output mesh_pkg::flit_s [`MESH_PORTS-1:1]    req_out_flit_o
   , input [`MESH_PORTS-1:1]                      req_out_credit_i

   , input [`MESH_PORTS-1:1]                      resp_in_v_i
   , input mesh_pkg::flit_s [`MESH_PORTS-1:1]     resp_in_flit_i
   , output [`MESH_PORTS-1:1]                     resp_in_credit_o
   , output [`MESH_PORTS-1:1]                     resp_out_v_o
   , output mesh_pkg::flit_s [`MESH_PORTS-1:1]    resp_out_flit_o
   , input [`MESH_PORTS-1:1]                      resp_out_credit_i
   );

  logic [`MESH_PORTS-1:0]            req_in_v, req_in_credit, req_out_v, req_out_credit;
  mesh_pkg::flit_s [`MESH_PORTS-1:0] req_in_flit, req_out_flit;
  logic [`MESH_PORTS-1:0]            resp_in_v, resp_in_credit, resp_out_v, resp_out_credit;
  mesh_pkg::flit_s [`MESH_PORTS-1:0] resp_in_flit, resp_out_flit;

  logic                              sp_req_credit;
  logic                              sp_resp_v;
  mesh_pkg::flit_s                   sp_resp_flit;

  //////////////////////////////////////////////////////////////
  // request network, local output feeds the scratchpad
  //////////////////////////////////////////////////////////////
  assign req_in_v        = {req_in_v_i, 1'b0};
  assign req_in_flit     = {req_in_flit_i, mesh_pkg::flit_s'('0)};
  assign req_in_credit_o = req_in_credit[`MESH_PORTS-1:1];
  assign req_out_v_o     = req_out_v[`MESH_PORTS-1:1];
  assign req_out_flit_o  = req_out_flit[`MESH_PORTS-1:1];
  assign req_out_credit  = {req_out_credit_i, sp_req_credit};

  mesh_router
    #(.tile_x_p(tile_x_p)
      ,.tile_y_p(tile_y_p)
      )
    req_router
      (.core_clk_i(core_clk_i)
       ,.rst_n_i(rst_n_i)
       ,.in_v_i(req_in_v)
       ,.in_flit_i(req_in_flit)
       ,.in_credit_o(req_in_credit)
       ,.out_v_o(req_out_v)
       ,.out_flit_o(req_out_flit)
       ,.out_credit_i(req_out_credit)
       );

  tile_scratchpad
    #(.tile_x_p(tile_x_p)
      ,.tile_y_p(tile_y_p)
      )
    scratchpad
      (.core_clk_i(core_clk_i)
       ,.rst_n_i(rst_n_i)
       ,.req_v_i(req_out_v[mesh_pkg::e_dir_p])
       ,.req_flit_i(req_out_flit[mesh_pkg::e_dir_p])
       ,.req_credit_o(sp_req_credit)
       ,.resp_v_o(sp_resp_v)
       ,.resp_flit_o(sp_resp_flit)
       ,.resp_credit_i(resp_in_credit[mesh_pkg::e_dir_p])
       );

  //////////////////////////////////////////////////////////////
  // response network, local input comes from the scratchpad
  //////////////////////////////////////////////////////////////
  assign resp_in_v        = {resp_in_v_i, sp_resp_v};
  assign resp_in_flit     = {resp_in_flit_i, sp_resp_flit};
  assign resp_in_credit_o = resp_in_credit[`MESH_PORTS-1:1];
  assign resp_out_v_o     = resp_out_v[`MESH_PORTS-1:1];
  assign resp_out_flit_o  = resp_out_flit[`MESH_PORTS-1:1];
  // responses never target a tile, so the local output never sends
  assign resp_out_credit  = {resp_out_credit_i, 1'b0};

  mesh_router
    #(.tile_x_p(tile_x_p)
      ,.tile_y_p(tile_y_p)
      )
    resp_router
      (.core_clk_i(core_clk_i)
       ,.rst_n_i(rst_n_i)
       ,.in_v_i(resp_in_v)
       ,.in_flit_i(resp_in_flit)
       ,.in_credit_o(resp_in_credit)
       ,.out_v_o(resp_out_v)
       ,.out_flit_o(resp_out_flit)
       ,.out_credit_i(resp_out_credit)
       );

endmodule

// ==== tile/tile_scratchpad.sv ====
`timescale 1ns/1ps
`include "mesh_defs.svh"

module tile_scratchpad
  #(parameter int tile_x_p = 1
    , parameter int tile_y_p = 0
    )
  (input                      core_clk_i
   , input                    rst_n_i
   , input                    req_v_i
   , input mesh_pkg::flit_s   req_flit_i
   , output                   req_credit_o
   , output logic             resp_v_o
   , output mesh_pkg::flit_s  resp_flit_o
   , input                    resp_credit_i
   );

  localparam int words_lp = 1 << `MESH_ADDR_W;
  localparam int cnt_w_lp = $clog2(`MESH_CREDITS + 1);

  logic [`MESH_DATA_W-1:0] mem [words_lp];
  mesh_pkg::flit_s         slot;
  logic                    slot_empty;
  logic                    slot_pop;
  logic [cnt_w_lp-1:0]     resp_cnt;

  // a request is served only when the response can be sent
  assign slot_pop = ~slot_empty & (resp_cnt != '0);

  // request holding buffer, sized to the router's credit count
  credit_fifo req_slot
    (.core_clk_i(core_clk_i)
     ,.rst_n_i(rst_n_i)
     ,.push_i(req_v_i)
     ,.flit_i(req_flit_i)
     ,.pop_i(slot_pop)
     ,.empty_o(slot_empty)
     ,.flit_o(slot)
     ,.credit_o(req_credit_o)
     );

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      for (int w = 0; w < words_lp; w++)
        mem[w] <= '0;
    end
    else if (slot_pop && slot.op == mesh_pkg::e_op_wr)
      mem[slot.addr] <= slot.data;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_o <= 1'b0;
      resp_cnt <= cnt_w_lp'(`MESH_CREDITS);
    end
    else
    begin
      resp_v_o <= slot_pop;
      resp_cnt <= resp_cnt + cnt_w_lp'(resp_credit_i) - cnt_w_lp'(slot_pop);
    end
  end

  // response goes back to the requester
  always_ff @(posedge core_clk_i)
  begin
    if (slot_pop)
    begin
      resp_flit_o.op    <= (slot.op == mesh_pkg::e_op_wr) ? mesh_pkg::e_op_wack
                                                          : mesh_pkg::e_op_rdata;
      resp_flit_o.dst_x <= slot.src_x;
      resp_flit_o.dst_y <= slot.src_y;
      resp_flit_o.src_x <= `MESH_XC_W'(tile_x_p);
      resp_flit_o.src_y <= `MESH_YC_W'(tile_y_p);
      resp_flit_o.addr  <= slot.addr;
      resp_flit_o.data  <= (slot.op == mesh_pkg::e_op_wr) ? slot.data : mem[slot.addr];
    end
  end

endmodule
